/* hdl/rx_queue_pkg.sv */
// ----------------------------------------------------------------------
// data format of the receive queue: word and control widths, packet
// size limits, header field layout and FIFO depths
// referenced by scope from the RTL and the testbench
// ----------------------------------------------------------------------
package rx_queue_pkg;

   // word layout
   localparam int HALF_W = 16;              // one MAC halfword
   localparam int DATA_W = 64;              // one queue word
   localparam int CTRL_W = DATA_W / 8;      // one control bit per byte
   localparam int LANES  = DATA_W / HALF_W; // halfwords per word

   // packet limits
   localparam int MAX_PKT_BYTES = 2048;     // longer is oversize
   localparam int MAX_PKT_WORDS = MAX_PKT_BYTES / CTRL_W;
   localparam int BYTE_CNT_W    = 12;
   localparam int WORD_CNT_W    = 9;

   // fifo sizes, log2 of entries
   localparam int DATA_DEPTH_BITS = 9;      // 512 words, two max packets
   localparam int STAT_DEPTH_BITS = 6;

   // header word
   localparam logic [CTRL_W-1:0] STAGE_NUMBER = '1; // ctrl of a header word
   localparam int HDR_PORT_LSB = 16;        // byte length sits below this
   localparam int HDR_WLEN_LSB = 32;

endpackage

/* hdl/rx_queue_fsm_pkg.sv */
// ----------------------------------------------------------------------
// state encodings for the receive queue writer and reader FSMs
// ----------------------------------------------------------------------
package rx_queue_fsm_pkg;

   // writer on the MAC side
   typedef enum logic [1:0] {
      PACK_IDLE,  // waiting for first halfword
      PACK_RCV,   // packing halfwords into words
      PACK_PAD,   // zero filling the final word
      PACK_DROP   // discarding until mac_last
   } pack_state_t;

   // reader on the output side
   typedef enum logic [1:0] {
      READ_WAIT,    // no status entry yet
      READ_HEADER,  // sending the length/port word
      READ_BODY     // forwarding or discarding words
   } read_state_t;

endpackage

/* hdl/sync_fifo.sv */
// ----------------------------------------------------------------------
// single clock first-word-fall-through FIFO with a fill count
// head entry shows on dout whenever empty is low, rd_en pops it
// ----------------------------------------------------------------------
module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr_en,
   input  logic [WIDTH-1:0]      din,
   input  logic                  rd_en,
   output logic [WIDTH-1:0]      dout,
   output logic                  empty,
   output logic                  full,
   output logic [DEPTH_BITS:0]   count
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && !full;   // writes into a full fifo are lost
   assign do_rd = rd_en && !empty;

   assign empty = (count == '0);
   assign full  = (count == (DEPTH_BITS + 1)'(DEPTH));
   assign dout  = mem[rd_ptr];      // fall-through head

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1; // pointers wrap at DEPTH
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // idle or both at once
         endcase
      end
   end

endmodule

/* hdl/rx_word_packer.sv */
// ----------------------------------------------------------------------
// MAC side writer: packs four halfwords into a 64 bit word plus ctrl,
// zero pads the final word, marks its last byte and writes one status
// entry per packet; drops packets that may not fit or run oversize
// ----------------------------------------------------------------------
module rx_word_packer (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    mac_valid,
   input  logic [rx_queue_pkg::HALF_W-1:0]         mac_data,
   input  logic                                    mac_last,
   input  logic                                    mac_odd,
   input  logic                                    mac_bad,
   input  logic [rx_queue_pkg::DATA_DEPTH_BITS:0]  data_count,
   input  logic                                    stat_full,
   output logic                                    word_wr,
   output logic [71:0]                             word_data,
   output logic                                    stat_wr,
   output logic [12:0]                             stat_data
);

   localparam int HALF_BYTES = rx_queue_pkg::HALF_W / 8;
   localparam int LAST_LANE  = rx_queue_pkg::LANES - 1;

   rx_queue_fsm_pkg::pack_state_t state, state_nxt;

   logic [rx_queue_pkg::HALF_W-1:0]      lane_q [LAST_LANE]; // first three lanes
   logic [1:0]                           lane;
   logic [rx_queue_pkg::BYTE_CNT_W-1:0]  byte_cnt;           // bytes before this halfword
   logic [rx_queue_pkg::CTRL_W-1:0]      pend_ctrl;          // held across padding
   logic                                 pend_good;
   logic [rx_queue_pkg::BYTE_CNT_W-1:0]  pend_len;

   logic [rx_queue_pkg::DATA_DEPTH_BITS:0] free_words;
   logic                                 room;
   logic                                 take;
   logic                                 over;
   logic [1:0]                           inc;
   logic [rx_queue_pkg::HALF_W-1:0]      hw_in;
   logic [rx_queue_pkg::HALF_W-1:0]      tail;
   logic [rx_queue_pkg::CTRL_W-1:0]      mark;
   logic [rx_queue_pkg::CTRL_W-1:0]      word_ctrl;
   logic                                 end_good;
   logic [rx_queue_pkg::BYTE_CNT_W-1:0]  end_len;
   logic                                 stat_good;
   logic [rx_queue_pkg::BYTE_CNT_W-1:0]  stat_len;

   // ------------------------------------------------------------------
   // admission and per-halfword decode
   // ------------------------------------------------------------------
   assign free_words = (rx_queue_pkg::DATA_DEPTH_BITS + 1)'(2 ** rx_queue_pkg::DATA_DEPTH_BITS)
                       - data_count;
   assign room = (free_words >= (rx_queue_pkg::DATA_DEPTH_BITS + 1)'(rx_queue_pkg::MAX_PKT_WORDS))
                 && !stat_full;
   assign take = mac_valid && ((state == rx_queue_fsm_pkg::PACK_RCV) ||
                               (state == rx_queue_fsm_pkg::PACK_IDLE && room));

   assign inc   = (mac_last && mac_odd) ? 2'd1 : 2'd2;
   assign hw_in = (mac_last && mac_odd) ? {mac_data[15:8], 8'h00} : mac_data; // odd low byte is pad
   // max size is a word multiple, so this only hits in the last lane
   assign over  = !mac_last &&
                  (byte_cnt == rx_queue_pkg::BYTE_CNT_W'(rx_queue_pkg::MAX_PKT_BYTES - HALF_BYTES));
   assign mark  = {1'b1, {(rx_queue_pkg::CTRL_W - 1){1'b0}}} >> {lane, ~(mac_last & mac_odd)};

   assign end_good = mac_last && !mac_bad;
   assign end_len  = over ? rx_queue_pkg::BYTE_CNT_W'(rx_queue_pkg::MAX_PKT_BYTES)
                          : byte_cnt + rx_queue_pkg::BYTE_CNT_W'(inc);

   assign word_data = {word_ctrl, lane_q[0], lane_q[1], lane_q[2], tail};
   assign stat_data = {stat_good, stat_len};

   always_comb begin
      state_nxt = state;
      word_wr   = 1'b0;
      stat_wr   = 1'b0;
      word_ctrl = '0;
      tail      = hw_in;
      stat_good = end_good;
      stat_len  = end_len;
      case (state)
         rx_queue_fsm_pkg::PACK_IDLE, rx_queue_fsm_pkg::PACK_RCV: begin
            if (take) begin
               word_wr = (lane == 2'(LAST_LANE));            // fourth halfword closes word
               if (mac_last || over) begin
                  if (lane == 2'(LAST_LANE)) begin
                     word_ctrl = mark;
                     stat_wr   = 1'b1;
                     state_nxt = over ? rx_queue_fsm_pkg::PACK_DROP
                                      : rx_queue_fsm_pkg::PACK_IDLE;
                  end else begin
                     state_nxt = rx_queue_fsm_pkg::PACK_PAD;
                  end
               end else begin
                  state_nxt = rx_queue_fsm_pkg::PACK_RCV;
               end
            end else if (mac_valid && !mac_last) begin
               state_nxt = rx_queue_fsm_pkg::PACK_DROP; // no room for a max packet
            end
         end
         rx_queue_fsm_pkg::PACK_PAD: begin
            tail      = '0;
            stat_good = pend_good;
            stat_len  = pend_len;
            if (lane == 2'(LAST_LANE)) begin
               word_wr   = 1'b1;
               stat_wr   = 1'b1;
               word_ctrl = pend_ctrl;
               state_nxt = rx_queue_fsm_pkg::PACK_IDLE;
            end
         end
         rx_queue_fsm_pkg::PACK_DROP: begin
            if (mac_valid && mac_last) state_nxt = rx_queue_fsm_pkg::PACK_IDLE;
         end
         default: state_nxt = rx_queue_fsm_pkg::PACK_IDLE;
      endcase
   end

   // ------------------------------------------------------------------
   // control state
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= rx_queue_fsm_pkg::PACK_IDLE;
         lane     <= '0;
         byte_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (take) begin
            lane     <= lane + 1'b1;                    // wraps after last lane
            byte_cnt <= byte_cnt + rx_queue_pkg::BYTE_CNT_W'(inc);
         end else if (state == rx_queue_fsm_pkg::PACK_PAD) begin
            lane <= lane + 1'b1;
         end
         if (state_nxt == rx_queue_fsm_pkg::PACK_IDLE) begin
            lane     <= '0;
            byte_cnt <= '0;
         end
      end
   end

   // lane payload and pending status
   always_ff @(posedge clk) begin
      if (take && lane != 2'(LAST_LANE)) lane_q[lane] <= hw_in;
      if (state == rx_queue_fsm_pkg::PACK_PAD && lane != 2'(LAST_LANE)) lane_q[lane] <= '0;
      if (take && (mac_last || over)) begin
         pend_ctrl <= mark;
         pend_good <= end_good;
         pend_len  <= end_len;
      end
   end

endmodule

/* hdl/rx_pkt_reader.sv */
// ----------------------------------------------------------------------
// output side reader: takes one status entry per packet, optionally
// sends a length/port header word, then forwards a good packet under
// out_rdy or pops a bad one word per cycle without writing it out
// ----------------------------------------------------------------------
module rx_pkt_reader #(
   parameter int ENABLE_HEADER = 1,
   parameter int PORT_NUMBER   = 0
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 stat_empty,
   input  logic [12:0]                          stat_data,
   output logic                                 stat_rd,
   input  logic                                 word_empty,
   input  logic [71:0]                          word_data,
   output logic                                 word_rd,
   output logic [rx_queue_pkg::DATA_W-1:0]      out_data,
   output logic [rx_queue_pkg::CTRL_W-1:0]      out_ctrl,
   output logic                                 out_wr,
   input  logic                                 out_rdy
);

   localparam int FIELD_W  = rx_queue_pkg::HDR_WLEN_LSB - rx_queue_pkg::HDR_PORT_LSB;
   localparam int BYTE_LSB = $clog2(rx_queue_pkg::CTRL_W); // byte-in-word bits

   rx_queue_fsm_pkg::read_state_t state, state_nxt;

   logic                                pkt_good;
   logic [rx_queue_pkg::BYTE_CNT_W-1:0] pkt_len;
   logic [rx_queue_pkg::WORD_CNT_W-1:0] word_len;
   logic [rx_queue_pkg::DATA_W-1:0]     header;
   logic                                out_wr_nxt;
   logic [rx_queue_pkg::DATA_W-1:0]     out_data_nxt;
   logic [rx_queue_pkg::CTRL_W-1:0]     out_ctrl_nxt;
   logic [rx_queue_pkg::CTRL_W-1:0]     head_ctrl;

   assign head_ctrl = word_data[71:64];

   // length in words, rounded up
   assign word_len = rx_queue_pkg::WORD_CNT_W'(pkt_len[rx_queue_pkg::BYTE_CNT_W-1:BYTE_LSB])
                   + rx_queue_pkg::WORD_CNT_W'(|pkt_len[BYTE_LSB-1:0]);

   always_comb begin
      header = '0;
      header[rx_queue_pkg::HDR_PORT_LSB-1:0]        = rx_queue_pkg::HDR_PORT_LSB'(pkt_len);
      header[rx_queue_pkg::HDR_PORT_LSB +: FIELD_W] = FIELD_W'(PORT_NUMBER);
      header[rx_queue_pkg::HDR_WLEN_LSB +: FIELD_W] = FIELD_W'(word_len);
   end

   // ------------------------------------------------------------------
   // reader FSM
   // ------------------------------------------------------------------
   always_comb begin
      state_nxt    = state;
      stat_rd      = 1'b0;
      word_rd      = 1'b0;
      out_wr_nxt   = 1'b0;
      out_data_nxt = word_data[rx_queue_pkg::DATA_W-1:0];
      out_ctrl_nxt = head_ctrl;
      case (state)
         rx_queue_fsm_pkg::READ_WAIT: begin
            if (!stat_empty) begin
               stat_rd   = 1'b1;                  // packet fully stored by now
               state_nxt = (stat_data[12] && ENABLE_HEADER != 0) ?
                           rx_queue_fsm_pkg::READ_HEADER : rx_queue_fsm_pkg::READ_BODY;
            end
         end
         rx_queue_fsm_pkg::READ_HEADER: begin
            out_data_nxt = header;
            out_ctrl_nxt = rx_queue_pkg::STAGE_NUMBER;
            if (out_rdy) begin
               out_wr_nxt = 1'b1;
               state_nxt  = rx_queue_fsm_pkg::READ_BODY;
            end
         end
         rx_queue_fsm_pkg::READ_BODY: begin
            if (!word_empty && (out_rdy || !pkt_good)) begin
               word_rd    = 1'b1;
               out_wr_nxt = pkt_good;           // bad words just drain
               if (head_ctrl != '0) state_nxt = rx_queue_fsm_pkg::READ_WAIT;
            end
         end
         default: state_nxt = rx_queue_fsm_pkg::READ_WAIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= rx_queue_fsm_pkg::READ_WAIT;
         out_wr <= 1'b0;
      end else begin
         state  <= state_nxt;
         out_wr <= out_wr_nxt;
      end
   end

   // output payload and popped status
   always_ff @(posedge clk) begin
      out_data <= out_data_nxt;
      out_ctrl <= out_ctrl_nxt;
      if (stat_rd) begin
         pkt_good <= stat_data[12];
         pkt_len  <= stat_data[rx_queue_pkg::BYTE_CNT_W-1:0];
      end
   end

endmodule

/* hdl/rx_queue.sv */
// ----------------------------------------------------------------------
// store-and-forward receive queue for one port, single clock
// MAC halfwords in, 64 bit words with ctrl out under out_rdy
// writer -> data and status FIFOs -> reader
// ----------------------------------------------------------------------
module rx_queue #(
   parameter int ENABLE_HEADER = 1,
   parameter int PORT_NUMBER   = 3
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              mac_valid,
   input  logic [rx_queue_pkg::HALF_W-1:0]   mac_data,
   input  logic                              mac_last,
   input  logic                              mac_odd,
   input  logic                              mac_bad,
   output logic [rx_queue_pkg::DATA_W-1:0]   out_data,
   output logic [rx_queue_pkg::CTRL_W-1:0]   out_ctrl,
   output logic                              out_wr,
   input  logic                              out_rdy
);

   // data path, ctrl above data
   logic                                   word_wr;
   logic [71:0]                            word_wdata;
   logic                                   word_rd;
   logic [71:0]                            word_rdata;
   logic                                   word_empty;
   logic [rx_queue_pkg::DATA_DEPTH_BITS:0] data_count;

   // status path, good flag above byte length
   logic                                   stat_wr;
   logic [12:0]                            stat_wdata;
   logic                                   stat_rd;
   logic [12:0]                            stat_rdata;
   logic                                   stat_empty;
   logic                                   stat_full;

   rx_word_packer u_packer (
      .clk        (clk),
      .reset      (reset),
      .mac_valid  (mac_valid),
      .mac_data   (mac_data),
      .mac_last   (mac_last),
      .mac_odd    (mac_odd),
      .mac_bad    (mac_bad),
      .data_count (data_count),
      .stat_full  (stat_full),
      .word_wr    (word_wr),
      .word_data  (word_wdata),
      .stat_wr    (stat_wr),
      .stat_data  (stat_wdata)
   );

   sync_fifo #(
      .WIDTH      (72),
      .DEPTH_BITS (rx_queue_pkg::DATA_DEPTH_BITS)
   ) data_fifo (
      .clk   (clk),
      .reset (reset),
      .wr_en (word_wr),
      .din   (word_wdata),
      .rd_en (word_rd),
      .dout  (word_rdata),
      .empty (word_empty),
      .full  (),                 // admission keeps room for a max packet
      .count (data_count)
   );

   sync_fifo #(
      .WIDTH      (13),
      .DEPTH_BITS (rx_queue_pkg::STAT_DEPTH_BITS)
   ) stat_fifo (
      .clk   (clk),
      .reset (reset),
      .wr_en (stat_wr),
      .din   (stat_wdata),
      .rd_en (stat_rd),
      .dout  (stat_rdata),
      .empty (stat_empty),
      .full  (stat_full),
      .count ()
   );

   rx_pkt_reader #(
      .ENABLE_HEADER (ENABLE_HEADER),
      .PORT_NUMBER   (PORT_NUMBER)
   ) u_reader (
      .clk        (clk),
      .reset      (reset),
      .stat_empty (stat_empty),
      .stat_data  (stat_rdata),
      .stat_rd    (stat_rd),
      .word_empty (word_empty),
      .word_data  (word_rdata),
      .word_rd    (word_rd),
      .out_data   (out_data),
      .out_ctrl   (out_ctrl),
      .out_wr     (out_wr),
      .out_rdy    (out_rdy)
   );

endmodule

/* test/rx_queue_model.svh */
// ----------------------------------------------------------------------
// testbench helpers for the receive queue: LFSR random source, packet
// payload generator and the queue of expected output words
// included inside the testbench top module
// ----------------------------------------------------------------------
`ifndef RX_QUEUE_MODEL_SVH
`define RX_QUEUE_MODEL_SVH

localparam logic [15:0] LFSR_SEED = 16'd68;
localparam int PKT_BUF = 2064;              // room for an oversize frame

logic [15:0] lfsr = LFSR_SEED;
logic [7:0]  pkt_bytes [0:PKT_BUF-1];       // payload of the current packet
int          pkt_len;
logic        pkt_bad;
logic [71:0] exp_q [$];                     // ctrl above data, in output order

// fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_step();
   logic fb;
   fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
   lfsr = {lfsr[14:0], fb};
   return fb;
endfunction

// n random bits, one step per bit
function automatic int rand_bits(input int n);
   int v;
   v = 0;
   for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_step());
   return v;
endfunction

// random payload of len bytes
task automatic make_packet(input int len, input logic bad);
   pkt_len = len;
   pkt_bad = bad;
   for (int i = 0; i < len; i++) pkt_bytes[i] = 8'(rand_bits(8));
endtask

// ----------------------------------------------------------------------
// reference model: header word, then payload packed from the high end,
// zero padding and one ctrl bit on the last valid byte
// ----------------------------------------------------------------------
task automatic model_packet();
   int          words;
   int          idx;
   logic [71:0] w;
   words = (pkt_len + 7) / 8;               // round up to whole words
   if (HDR_EN != 0) begin
      w        = '0;
      w[71:64] = 8'hff;                     // header marker
      w[15:0]  = 16'(pkt_len);
      w[31:16] = 16'(PORT);
      w[47:32] = 16'(words);
      exp_q.push_back(w);
   end
   for (int k = 0; k < words; k++) begin
      w = '0;
      for (int b = 0; b < 8; b++) begin
         idx = k * 8 + b;
         if (idx < pkt_len) w[63 - 8 * b -: 8] = pkt_bytes[idx]; // byte 0 on top
      end
      if (k == words - 1) w[71 - (pkt_len - 1) % 8] = 1'b1;   // last byte marker
      exp_q.push_back(w);
   end
endtask

`endif

/* test/tb_rx_queue.sv */
// ----------------------------------------------------------------------
// testbench for the receive queue: random MAC traffic, bad and
// oversize frames, full-queue drops, checked word by word against
// the model queue at the output
// ----------------------------------------------------------------------
module tb_rx_queue;

   localparam int HDR_EN = 1;
   localparam int PORT   = 3;
   localparam int PERIOD = 100;

   logic                            clk;
   logic                            reset;
   logic                            mac_valid;
   logic [rx_queue_pkg::HALF_W-1:0] mac_data;
   logic                            mac_last;
   logic                            mac_odd;
   logic                            mac_bad;
   logic [rx_queue_pkg::DATA_W-1:0] out_data;
   logic [rx_queue_pkg::CTRL_W-1:0] out_ctrl;
   logic                            out_wr;
   logic                            out_rdy;

   int          errors      = 0;
   int          rule_errors = 0;            // handshake and reset checks
   int          err_start   = 0;
   int          tests_run   = 0;
   int          tests_bad   = 0;
   int          cycles      = 0;
   int          cycle_limit = 2000;         // grows with every packet sent
   string       cur_test    = "reset";
   logic        rdy_hold    = 1'b0;         // forces out_rdy low
   logic        rdy_at_edge;
   logic        rst_at_edge;
   logic [71:0] mon_word;

   `include "rx_queue_model.svh"

   rx_queue #(
      .ENABLE_HEADER (HDR_EN),
      .PORT_NUMBER   (PORT)
   ) DUT (
      .clk       (clk),
      .reset     (reset),
      .mac_valid (mac_valid),
      .mac_data  (mac_data),
      .mac_last  (mac_last),
      .mac_odd   (mac_odd),
      .mac_bad   (mac_bad),
      .out_data  (out_data),
      .out_ctrl  (out_ctrl),
      .out_wr    (out_wr),
      .out_rdy   (out_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------
   // stimulus steps, all on the falling edge
   // ------------------------------------------------------------------
   task automatic tick();
      @(negedge clk);
      mac_valid = 1'b0;
      mac_last  = 1'b0;
      mac_odd   = 1'b0;
      mac_bad   = 1'b0;
      out_rdy   = rdy_hold ? 1'b0 : (rand_bits(2) != 0); // ready 3 of 4
   endtask

   // halfwords high byte first, then idle while the writer pads
   task automatic send_packet(input logic expect_out, input logic gaps);
      int halves;
      halves = (pkt_len + 1) / 2;
      cycle_limit += 2 * halves;
      if (expect_out && !pkt_bad) begin
         model_packet();
         cycle_limit += 2 * ((pkt_len + 7) / 8 + HDR_EN);
      end
      for (int h = 0; h < halves; h++) begin
         if (gaps && rand_bits(1) != 0) tick();
         tick();
         mac_valid = 1'b1;
         mac_data  = {pkt_bytes[2 * h], (2 * h + 1 < pkt_len) ? pkt_bytes[2 * h + 1] : 8'h00};
         mac_last  = (h == halves - 1);
         mac_odd   = (h == halves - 1) && (pkt_len % 2 == 1);
         mac_bad   = (h == halves - 1) && pkt_bad;
      end
      repeat (4 + (gaps ? rand_bits(2) : 0)) tick(); // covers up to 3 pad lanes
   endtask

   task automatic drain();
      while (exp_q.size() != 0) tick();
      repeat (20) tick();                    // room for a stray word to show
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      err_start = errors;
   endtask

   task automatic end_test(input int pkts);
      tests_run++;
      if (errors != err_start) tests_bad++;
      $display("%s: %0d packets, %0d errors", cur_test, pkts, errors - err_start);
   endtask

   // ------------------------------------------------------------------
   // monitor, outputs sampled on the falling edge
   // ------------------------------------------------------------------
   always @(posedge clk) rdy_at_edge <= out_rdy;   // what the DUT saw
   always @(posedge clk) rst_at_edge <= reset;

   always @(negedge clk) begin
      if (rst_at_edge) begin
         assert (out_wr === 1'b0) else begin
            $display("out_wr was not low while reset was asserted");
            errors++;
            rule_errors++;
         end
      end else if (out_wr === 1'b1) begin
         assert (rdy_at_edge === 1'b1) else begin
            $display("%s: out_wr high after a cycle with out_rdy low", cur_test);
            errors++;
            rule_errors++;
         end
         assert (exp_q.size() != 0) else begin
            $display("%s: output word %h came out with none expected", cur_test,
                     {out_ctrl, out_data});
            errors++;
         end
         if (exp_q.size() != 0) begin
            mon_word = exp_q.pop_front();
            assert ({out_ctrl, out_data} === mon_word) else begin
               $display("FAILED %s: expected %h actual %h", cur_test, mon_word,
                        {out_ctrl, out_data});
               errors++;
            end
         end
      end
   end

   // run limit, raised as packets are queued
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run stopped after %0d cycles, output stalled", cycles);
         $display("test failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial begin
      reset     = 1'b1;
      mac_valid = 1'b0;
      mac_data  = '0;
      mac_last  = 1'b0;
      mac_odd   = 1'b0;
      mac_bad   = 1'b0;
      out_rdy   = 1'b0;
      repeat (3) tick();                     // reset over 3 rising edges
      reset = 1'b0;

      start_test("random_good");
      for (int p = 0; p < 150; p++) begin
         make_packet(1 + rand_bits(7) % 120, 1'b0);
         send_packet(1'b1, 1'b1);
      end
      drain();
      end_test(150);

      start_test("bad_frames");              // about one in four bad
      for (int p = 0; p < 40; p++) begin
         make_packet(1 + rand_bits(7) % 120, rand_bits(2) == 0);
         send_packet(1'b1, 1'b1);
      end
      drain();
      end_test(40);

      start_test("final_word");              // every lane and odd/even end
      for (int n = 1; n <= 24; n++) begin
         make_packet(n, 1'b0);
         send_packet(1'b1, 1'b1);
      end
      drain();
      end_test(24);

      start_test("full_drop");
      rdy_hold = 1'b1;
      tick();
      for (int p = 0; p < 4; p++) begin
         make_packet(2048, 1'b0);
         send_packet(p < 2, 1'b0);           // 512 words hold two max packets
      end
      rdy_hold = 1'b0;
      drain();
      make_packet(1 + rand_bits(6), 1'b0);
      send_packet(1'b1, 1'b1);
      drain();
      end_test(5);

      start_test("oversize");
      make_packet(2050, 1'b0);               // cut at 2048 and marked bad
      send_packet(1'b0, 1'b0);
      make_packet(1 + rand_bits(6), 1'b0);
      send_packet(1'b1, 1'b1);
      drain();
      end_test(2);

      cur_test = "output_rules";
      assert (exp_q.size() == 0) else begin
         $display("output_rules: %0d expected words never came out", exp_q.size());
         errors++;
         rule_errors++;
      end
      tests_run++;
      if (rule_errors != 0) tests_bad++;
      $display("output_rules: %0d errors", rule_errors);

      $display("tests run %0d, tests with errors %0d, total errors %0d",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* rx_queue.f */
+incdir+test
hdl/rx_queue_pkg.sv
hdl/rx_queue_fsm_pkg.sv
hdl/sync_fifo.sv
hdl/rx_word_packer.sv
hdl/rx_pkt_reader.sv
hdl/rx_queue.sv
test/tb_rx_queue.sv

/* run_sim.sh */
#!/bin/sh
# builds the receive queue testbench with Verilator, runs it and
# scans the log for the failure line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
   -f rx_queue.f --top-module tb_rx_queue \
   -Mdir "$BUILD_DIR" -o sim_rx_queue
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./"$BUILD_DIR"/sim_rx_queue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" "$LOG"; then
   exit 1
fi
exit 0
